// ==== src.f ====
+incdir+logic
logic/copperv_pkg.sv
logic/copperv_ctrl_if.sv
logic/idecoder.sv
logic/register_file.sv
logic/arith_logic_unit.sv
logic/control_unit.sv
logic/copperv.sv
sim/copperv_asserts.sv
sim/copperv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module copperv_tb -o copperv_sim
./obj_dir/copperv_sim | tee sim.log

if grep -qF "** FAIL **" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -qF "** PASS **" sim.log; then
    echo "simulation ended early"
    exit 1
fi
echo "simulation passed"

// ==== sim/copperv_tb.sv ====
`timescale 1ns/10ps
`include "copperv_macros.svh"

module copperv_tb import copperv_pkg::*; ();

    localparam int MEM_WORDS = 256;
    // one memory size above the default, so word 0 is still fetched first
    localparam pc_t PC_INIT = pc_t'(`COPPERV_PC_INIT + 4 * MEM_WORDS);
    localparam int SEED = 65221;
    localparam int NUM_INST = 2000;
    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    logic i_i_raddr_ready;
    logic i_i_rdata_valid;
    inst_t i_i_rdata;
    logic o_i_raddr_valid;
    pc_t o_i_raddr;

    inst_t imem [MEM_WORDS];
    data_t model_regs [32];
    pc_t model_pc;

    copperv #(
        .pc_init(PC_INIT)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .i_i_raddr_ready(i_i_raddr_ready),
        .i_i_rdata_valid(i_i_rdata_valid),
        .i_i_rdata(i_i_rdata),
        .o_i_raddr_valid(o_i_raddr_valid),
        .o_i_raddr(o_i_raddr)
    );

    bind copperv copperv_asserts i_asserts (
        .clk(clk),
        .rst(rst),
        .i_raddr_valid(o_i_raddr_valid),
        .i_raddr(o_i_raddr),
        .i_raddr_ready(i_i_raddr_ready),
        .i_rdata_valid(i_i_rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("** FAIL **");
        $fatal(1, "test stopped");
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic inst_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // sub only exists with funct3 000
    function automatic inst_t enc_r(input logic sub, input reg_idx_t rs2, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {1'b0, sub && f3 == 3'b000, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // only x0 to x7 hold known values
    function automatic reg_idx_t rand_reg();
        return reg_idx_t'($urandom % 8);
    endfunction

    function automatic logic [2:0] alu_funct3();
        logic [2:0] f3;
        f3 = 3'($urandom);
        // shifts stay out of the programs
        if (f3[1:0] == 2'b01) begin
            f3 = 3'b000;
        end
        return f3;
    endfunction

    task automatic build_program();
        int off;
        for (int r = 1; r < 8; r++) begin
            imem[2*r-2] = enc_u(20'($urandom), reg_idx_t'(r));
            imem[2*r-1] = enc_i(12'($urandom), reg_idx_t'(r), 3'b000, reg_idx_t'(r));
        end
        for (int i = 14; i < MEM_WORDS; i++) begin
            case ($urandom % 16)
                0, 1: imem[i] = enc_u(20'($urandom), rand_reg());
                2, 3, 4, 5: imem[i] = enc_i(12'($urandom), rand_reg(), alu_funct3(), rand_reg());
                6, 7, 8, 9: begin
                    imem[i] = enc_r(1'($urandom), rand_reg(), rand_reg(), alu_funct3(), rand_reg());
                end
                10, 11, 12, 13: begin
                    off = 4 * (1 + int'($urandom % 8));
                    // mostly forward and kept inside the memory
                    if ((i > 16 && $urandom % 8 == 0) || i + off / 4 >= MEM_WORDS) begin
                        off = -off;
                    end
                    imem[i] = enc_b(13'(off), rand_reg(), rand_reg(),
                                    {1'($urandom), 1'b0, 1'($urandom)});
                end
                default: begin
                    // bit 0 cleared is never a supported opcode
                    imem[i] = $urandom & 32'hffff_fffe;
                end
            endcase
        end
    endtask

    task automatic model_step(input inst_t w);
        reg_idx_t rd;
        logic [2:0] f3;
        data_t a;
        data_t b;
        data_t res;
        logic wr;
        logic taken;
        rd = w[11:7];
        f3 = w[14:12];
        a = model_regs[w[19:15]];
        // opcode bit 5 selects rs2 over the I immediate
        b = w[5] ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        res = '0;
        wr = 1'b0;
        taken = 1'b0;
        case (w[6:0])
            7'b0110111: begin
                res = {w[31:12], 12'b0};
                wr = 1'b1;
            end
            7'b0010011, 7'b0110011: begin
                wr = 1'b1;
                case (f3)
                    3'b000: res = (w[5] && w[30]) ? a - b : a + b;
                    3'b010: res = {31'b0, $signed(a) < $signed(b)};
                    3'b011: res = {31'b0, a < b};
                    3'b100: res = a ^ b;
                    3'b110: res = a | b;
                    3'b111: res = a & b;
                    default: wr = 1'b0;
                endcase
            end
            7'b1100011: begin
                case (f3)
                    3'b000: taken = (a == b);
                    3'b001: taken = (a != b);
                    3'b100: taken = ($signed(a) < $signed(b));
                    3'b101: taken = ($signed(a) >= $signed(b));
                    default: taken = 1'b0;
                endcase
            end
            default: begin
            end
        endcase
        if (wr && rd != '0) begin
            model_regs[rd] = res;
        end
        if (taken) begin
            model_pc = model_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end else begin
            model_pc = model_pc + 32'd4;
        end
    endtask

    task automatic wait_fetch();
        int waited;
        waited = 0;
        while (!o_i_raddr_valid) begin
            if (waited == TIMEOUT) begin
                $display("timeout: no fetch request within %0d cycles", TIMEOUT);
                stop_on_failure();
            end
            @(posedge clk);
            #2;
            waited++;
        end
        check_pc(o_i_raddr, model_pc, "fetch address");
    endtask

    task automatic serve_fetch();
        int delay;
        pc_t addr;
        inst_t word;
        delay = $urandom % 4;
        repeat (delay) begin
            @(posedge clk);
            #2;
        end
        addr = o_i_raddr;
        i_i_raddr_ready = 1'b1;
        @(posedge clk);
        #2;
        i_i_raddr_ready = 1'b0;
        delay = $urandom % 4;
        repeat (delay) begin
            @(posedge clk);
            #2;
        end
        word = imem[addr[9:2]];
        i_i_rdata = word;
        i_i_rdata_valid = 1'b1;
        @(posedge clk);
        #2;
        i_i_rdata_valid = 1'b0;
        // junk on the bus between beats
        i_i_rdata = $urandom;
        model_step(word);
    endtask

    initial begin
        int unsigned seed_val;
        rst = 1'b0;
        i_i_raddr_ready = 1'b0;
        i_i_rdata_valid = 1'b0;
        i_i_rdata = '0;
        seed_val = $urandom(SEED);
        build_program();
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        model_pc = PC_INIT;
        repeat (3) @(posedge clk);
        #2;
        check_flag(o_i_raddr_valid, 1'b0, "fetch request in reset");
        rst = 1'b1;
        for (int n = 0; n < NUM_INST; n++) begin
            wait_fetch();
            serve_fetch();
        end
        // last instruction shows in the next fetch
        wait_fetch();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== sim/copperv_asserts.sv ====
`timescale 1ns/10ps

module copperv_asserts import copperv_pkg::*; (
    input logic clk,
    input logic rst,
    input logic i_raddr_valid,
    input pc_t i_raddr,
    input logic i_raddr_ready,
    input logic i_rdata_valid
);

    // no fetch request while reset is held
    property reset_quiet_p;
        @(posedge clk) !rst |=> !i_raddr_valid;
    endproperty

    // a request under back-pressure keeps its address
    property addr_held_p;
        @(posedge clk) disable iff (!rst)
            i_raddr_valid && !i_raddr_ready |=> i_raddr_valid && $stable(i_raddr);
    endproperty

    property single_request_p;
        @(posedge clk) disable iff (!rst)
            i_raddr_valid && i_raddr_ready |=> !i_raddr_valid;
    endproperty

    // data beats only land while the core waits
    property beat_in_wait_p;
        @(posedge clk) disable iff (!rst)
            i_rdata_valid |-> !i_raddr_valid;
    endproperty

    reset_quiet_a: assert property (reset_quiet_p)
        else $error("fetch request raised while reset was held");
    addr_held_a: assert property (addr_held_p)
        else $error("fetch request dropped or address changed before ready");
    single_request_a: assert property (single_request_p)
        else $error("fetch request still raised after the address transfer");
    beat_in_wait_a: assert property (beat_in_wait_p)
        else $error("read data arrived while a fetch request was raised");

endmodule

// ==== logic/copperv.sv ====
`timescale 1ns/10ps
`include "copperv_macros.svh"

module copperv import copperv_pkg::*; #(
    parameter pc_t pc_init = `COPPERV_PC_INIT
) (
    input logic clk,
    input logic rst,
    input logic i_i_raddr_ready,
    input logic i_i_rdata_valid,
    input inst_t i_i_rdata,
    output logic o_i_raddr_valid,
    output pc_t o_i_raddr
);

    // one instruction word per fetch
    localparam int unsigned INST_BYTES = `BUS_WIDTH / 8;

    copperv_ctrl_if ctrl ();

    pc_t pc;
    pc_t pc_next;
    inst_t inst;
    logic inst_valid;
    logic inst_fetch;
    logic rcomp;

    data_t imm;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    inst_type_e inst_type;
    funct_t funct;

    data_t rd_din;
    data_t rs1_dout;
    data_t rs2_dout;
    data_t alu_din2;
    data_t alu_dout;
    logic alu_comp;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= pc_init;
        end else if (ctrl.pc_next_sel != PC_NEXT_STALL) begin
            pc <= pc_next;
        end
    end

    always_comb begin
        case (ctrl.pc_next_sel)
            PC_NEXT_BRANCH: pc_next = pc + pc_t'(imm);
            default: pc_next = pc + pc_t'(INST_BYTES);
        endcase
    end

    assign o_i_raddr_valid = inst_fetch;
    assign o_i_raddr = pc;

    // read data is always accepted
    always_ff @(posedge clk) begin
        if (i_i_rdata_valid) begin
            inst <= i_i_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            inst_valid <= 1'b0;
            rcomp <= 1'b0;
        end else begin
            inst_valid <= i_i_rdata_valid;
            if (ctrl.rcomp_en) begin
                rcomp <= alu_comp;
            end
        end
    end

    assign alu_din2 = (ctrl.alu_din2_sel == ALU_DIN2_IMM) ? imm : rs2_dout;
    assign rd_din = (ctrl.rd_din_sel == RD_DIN_IMM) ? imm : alu_dout;

    idecoder idec (
        .i_inst(inst),
        .o_imm(imm),
        .o_rd(rd),
        .o_rs1(rs1),
        .o_rs2(rs2),
        .o_inst_type(inst_type),
        .o_funct(funct)
    );

    register_file regfile (
        .clk(clk),
        .i_rd_en(ctrl.rd_en),
        .i_rs1_en(ctrl.rs1_en),
        .i_rs2_en(ctrl.rs2_en),
        .i_rd(rd),
        .i_rs1(rs1),
        .i_rs2(rs2),
        .i_rd_din(rd_din),
        .o_rs1_dout(rs1_dout),
        .o_rs2_dout(rs2_dout)
    );

    arith_logic_unit alu (
        .i_din1(rs1_dout),
        .i_din2(alu_din2),
        .i_alu_op(ctrl.alu_op),
        .o_dout(alu_dout),
        .o_comp(alu_comp)
    );

    control_unit control (
        .clk(clk),
        .rst(rst),
        .i_raddr_ready(i_i_raddr_ready),
        .i_inst_valid(inst_valid),
        .i_rcomp(rcomp),
        .i_inst_type(inst_type),
        .i_funct(funct),
        .o_inst_fetch(inst_fetch),
        .ctrl(ctrl)
    );

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/10ps

module control_unit import copperv_pkg::*; (
    input logic clk,
    input logic rst,
    input logic i_raddr_ready,
    input logic i_inst_valid,
    input logic i_rcomp,
    input inst_type_e i_inst_type,
    input funct_t i_funct,
    output logic o_inst_fetch,
    copperv_ctrl_if.control ctrl
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic is_alu_type;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= STATE_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            STATE_RESET: state_next = STATE_FETCH;
            STATE_FETCH: begin
                if (i_raddr_ready) begin
                    state_next = STATE_WAIT;
                end
            end
            // operands are read in the inst_valid cycle
            STATE_WAIT: begin
                if (i_inst_valid) begin
                    state_next = STATE_EXEC;
                end
            end
            STATE_EXEC: begin
                state_next = (i_inst_type == INST_BRANCH) ? STATE_BRANCH : STATE_FETCH;
            end
            STATE_BRANCH: state_next = STATE_FETCH;
            default: state_next = STATE_RESET;
        endcase
    end

    assign o_inst_fetch = (state == STATE_FETCH);

    assign is_alu_type = (i_inst_type == INST_ALU_IMM) || (i_inst_type == INST_ALU_REG);

    assign ctrl.rs1_en = i_inst_valid;
    assign ctrl.rs2_en = i_inst_valid;
    assign ctrl.rd_en = (state == STATE_EXEC) && (is_alu_type || i_inst_type == INST_LUI);
    assign ctrl.rcomp_en = (state == STATE_EXEC) && (i_inst_type == INST_BRANCH);
    assign ctrl.rd_din_sel = (i_inst_type == INST_LUI) ? RD_DIN_IMM : RD_DIN_ALU;
    assign ctrl.alu_din2_sel = (i_inst_type == INST_ALU_IMM) ? ALU_DIN2_IMM : ALU_DIN2_RS2;

    always_comb begin
        ctrl.pc_next_sel = PC_NEXT_STALL;
        if (state == STATE_EXEC && i_inst_type != INST_BRANCH) begin
            ctrl.pc_next_sel = PC_NEXT_INCR;
        end else if (state == STATE_BRANCH) begin
            ctrl.pc_next_sel = i_rcomp ? PC_NEXT_BRANCH : PC_NEXT_INCR;
        end
    end

    always_comb begin
        ctrl.alu_op = ALU_ADD;
        if (i_inst_type == INST_BRANCH) begin
            case (i_funct[2:0])
                3'b000: ctrl.alu_op = ALU_EQ;
                3'b001: ctrl.alu_op = ALU_NE;
                3'b100: ctrl.alu_op = ALU_LT;
                3'b101: ctrl.alu_op = ALU_GE;
                default: ctrl.alu_op = ALU_EQ;
            endcase
        end else if (is_alu_type) begin
            // immediate forms always carry a zero top bit
            case (i_funct)
                4'b0000: ctrl.alu_op = ALU_ADD;
                4'b1000: ctrl.alu_op = ALU_SUB;
                4'b0010: ctrl.alu_op = ALU_SLT;
                4'b0011: ctrl.alu_op = ALU_SLTU;
                4'b0100: ctrl.alu_op = ALU_XOR;
                4'b0110: ctrl.alu_op = ALU_OR;
                4'b0111: ctrl.alu_op = ALU_AND;
                default: ctrl.alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

// ==== logic/arith_logic_unit.sv ====
`timescale 1ns/10ps

module arith_logic_unit import copperv_pkg::*; (
    input data_t i_din1,
    input data_t i_din2,
    input alu_op_e i_alu_op,
    output data_t o_dout,
    output logic o_comp
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq = (i_din1 == i_din2);
    assign lt_s = ($signed(i_din1) < $signed(i_din2));
    assign lt_u = (i_din1 < i_din2);

    always_comb begin
        o_dout = '0;
        case (i_alu_op)
            ALU_ADD: o_dout = i_din1 + i_din2;
            ALU_SUB: o_dout = i_din1 - i_din2;
            ALU_AND: o_dout = i_din1 & i_din2;
            ALU_OR: o_dout = i_din1 | i_din2;
            ALU_XOR: o_dout = i_din1 ^ i_din2;
            ALU_SLT: o_dout = data_t'(lt_s);
            ALU_SLTU: o_dout = data_t'(lt_u);
            default: o_dout = '0;
        endcase
    end

    // branch condition
    always_comb begin
        case (i_alu_op)
            ALU_EQ: o_comp = eq;
            ALU_NE: o_comp = !eq;
            ALU_LT: o_comp = lt_s;
            ALU_GE: o_comp = !lt_s;
            default: o_comp = 1'b0;
        endcase
    end

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/10ps

module register_file import copperv_pkg::*; (
    input logic clk,
    input logic i_rd_en,
    input logic i_rs1_en,
    input logic i_rs2_en,
    input reg_idx_t i_rd,
    input reg_idx_t i_rs1,
    input reg_idx_t i_rs2,
    input data_t i_rd_din,
    output data_t o_rs1_dout,
    output data_t o_rs2_dout
);

    data_t regs [32];

    always_ff @(posedge clk) begin
        if (i_rd_en && i_rd != '0) begin
            regs[i_rd] <= i_rd_din;
        end
    end

    // x0 is never written, so reads of it are forced
    always_ff @(posedge clk) begin
        if (i_rs1_en) begin
            o_rs1_dout <= (i_rs1 == '0) ? '0 : regs[i_rs1];
        end
        if (i_rs2_en) begin
            o_rs2_dout <= (i_rs2 == '0) ? '0 : regs[i_rs2];
        end
    end

endmodule

// ==== logic/idecoder.sv ====
`timescale 1ns/10ps

module idecoder import copperv_pkg::*; (
    input inst_t i_inst,
    output data_t o_imm,
    output reg_idx_t o_rd,
    output reg_idx_t o_rs1,
    output reg_idx_t o_rs2,
    output inst_type_e o_inst_type,
    output funct_t o_funct
);

    localparam logic [6:0] OPCODE_LUI = 7'b0110111;
    localparam logic [6:0] OPCODE_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_ALU_REG = 7'b0110011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic is_shift;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign o_rd = i_inst[11:7];
    assign o_rs1 = i_inst[19:15];
    assign o_rs2 = i_inst[24:20];

    // shifts use funct3 001 and 101
    assign is_shift = (funct3[1:0] == 2'b01);

    always_comb begin
        o_inst_type = INST_OTHER;
        o_imm = '0;
        o_funct = {1'b0, funct3};
        case (opcode)
            OPCODE_LUI: begin
                o_inst_type = INST_LUI;
                o_imm = {i_inst[31:12], 12'b0};
            end
            OPCODE_ALU_IMM: begin
                o_inst_type = is_shift ? INST_OTHER : INST_ALU_IMM;
                o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
            end
            OPCODE_ALU_REG: begin
                o_inst_type = is_shift ? INST_OTHER : INST_ALU_REG;
                o_funct = {i_inst[30], funct3};
            end
            OPCODE_BRANCH: begin
                // unsigned compares not supported
                o_inst_type = (funct3[2:1] == 2'b11) ? INST_OTHER : INST_BRANCH;
                o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                         i_inst[30:25], i_inst[11:8], 1'b0};
            end
            default: begin
                o_inst_type = INST_OTHER;
            end
        endcase
    end

endmodule

// ==== logic/copperv_ctrl_if.sv ====
`timescale 1ns/10ps

interface copperv_ctrl_if import copperv_pkg::*; ();

    logic rd_en;
    logic rs1_en;
    logic rs2_en;
    rd_din_sel_e rd_din_sel;
    alu_din2_sel_e alu_din2_sel;
    pc_next_sel_e pc_next_sel;
    logic rcomp_en;
    alu_op_e alu_op;

    modport control (
        output rd_en, rs1_en, rs2_en,
        output rd_din_sel, alu_din2_sel, pc_next_sel,
        output rcomp_en, alu_op
    );

    modport datapath (
        input rd_en, rs1_en, rs2_en,
        input rd_din_sel, alu_din2_sel, pc_next_sel,
        input rcomp_en, alu_op
    );

endinterface

// ==== logic/copperv_pkg.sv ====
`include "copperv_macros.svh"

package copperv_pkg;

    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [`PC_WIDTH-1:0] pc_t;
    typedef logic [`INST_WIDTH-1:0] inst_t;
    typedef logic [`REG_WIDTH-1:0] reg_idx_t;

    // funct3 plus bit 30
    typedef logic [3:0] funct_t;

    typedef enum logic [2:0] {
        INST_LUI,
        INST_ALU_IMM,
        INST_ALU_REG,
        INST_BRANCH,
        INST_OTHER
    } inst_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_EQ,
        ALU_NE,
        ALU_LT,
        ALU_GE
    } alu_op_e;

    typedef enum logic {
        RD_DIN_IMM,
        RD_DIN_ALU
    } rd_din_sel_e;

    typedef enum logic {
        ALU_DIN2_RS2,
        ALU_DIN2_IMM
    } alu_din2_sel_e;

    typedef enum logic [1:0] {
        PC_NEXT_STALL,
        PC_NEXT_INCR,
        PC_NEXT_BRANCH
    } pc_next_sel_e;

    typedef enum logic [2:0] {
        STATE_RESET,
        STATE_FETCH,
        STATE_WAIT,
        STATE_EXEC,
        STATE_BRANCH
    } ctrl_state_e;

endpackage

// ==== logic/copperv_macros.svh ====
`ifndef COPPERV_MACROS_SVH
`define COPPERV_MACROS_SVH

// bus and datapath widths
`define BUS_WIDTH 32
`define DATA_WIDTH 32
`define PC_WIDTH 32
`define INST_WIDTH 32

// register index
`define REG_WIDTH 5

// first fetch address after reset
`define COPPERV_PC_INIT 0

`endif
